// File: Bender.yml
package:
  name: tcm_subsys

sources:
  # package first, then leaves up to the top level
  - files:
      - hdl/tcm_pkg.sv
      - hdl/tcm_ram.sv
      - hdl/tcm_mems.sv
      - hdl/fetch_unit.sv
      - hdl/lsu.sv
      - hdl/tcm_subsys_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - verification/tcm_subsys_sva.sv
      - verification/tb_tcm_subsys.sv

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

// sequential instruction fetch through the itcm
// pc moves by 4 and wraps inside the itcm window, frozen while held
module fetch_unit #(
    parameter int ITCM_ADDR_WIDTH = 8  // itcm word address width
) (
    input  logic clk,
    input  logic rst_n_i,

    input  logic                               hold_i,       // itcm taken by load/store
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] inst_i,       // word for last cycle's pc
    output logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] pc_o,         // address issued this cycle

    output logic                               inst_valid_o, // fetch result strobe
    output logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] inst_pc_o,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] inst_data_o
);

    import tcm_pkg::*;

    localparam int OFF_WIDTH = ITCM_ADDR_WIDTH + 2;  // byte offset bits in the itcm

    logic [BUS_ADDR_WIDTH-1:0] pc_q;
    logic [BUS_ADDR_WIDTH-1:0] pc_nxt;
    logic [OFF_WIDTH-1:0]      pc_off;
    logic [OFF_WIDTH-1:0]      pc_off_nxt;

    logic [BUS_ADDR_WIDTH-1:0] issued_pc_q;  // address whose data returns now
    logic                      issued_q;     // last cycle was a real issue

    // next address
    // offset arithmetic drops the carry so the pc wraps at the window end
    assign pc_off     = OFF_WIDTH'(pc_q - ITCM_BASE_ADDR);
    assign pc_off_nxt = pc_off + OFF_WIDTH'(4);
    assign pc_nxt     = ITCM_BASE_ADDR + BUS_ADDR_WIDTH'(pc_off_nxt);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= ITCM_BASE_ADDR;
            issued_q <= 1'b0;
        end else begin
            issued_q <= !hold_i;   // held cycle brings back a nop
            if (!hold_i) begin
                pc_q <= pc_nxt;    // advance only after a real issue
            end
        end
    end

    // tag for the returning word
    always_ff @(posedge clk) begin
        issued_pc_q <= pc_q;
    end

    assign pc_o = pc_q;

    // result side, one cycle behind the issue
    assign inst_valid_o = issued_q;
    assign inst_pc_o    = issued_pc_q;
    assign inst_data_o  = inst_i;  // already steered by the memory block

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ps

// load/store unit
// turns a command into a masked word access, aligns the read data next cycle
module lsu (
    input  logic clk,
    input  logic rst_n_i,

    // command in, one cycle strobe
    input  logic                               cmd_valid_i,
    input  logic                               cmd_we_i,       // store when set
    input  logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] cmd_addr_i,     // naturally aligned byte addr
    input  tcm_pkg::access_size_e              cmd_size_i,
    input  logic                               cmd_unsigned_i, // zero extend loads
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] cmd_wdata_i,    // store data in low bits

    // memory block side
    output logic                               ex_req_o,
    output logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] ex_addr_o,
    output logic                               ex_we_o,
    output logic [3:0]                         ex_wmask_o,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] ex_wdata_o,
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] ex_rdata_i,
    input  logic                               ex_err_i,

    // response out, exactly one cycle after the command
    output logic                               rsp_valid_o,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                               rsp_err_o
);

    import tcm_pkg::*;

    logic [1:0] off;       // byte offset within the word
    logic [3:0] mask;

    // response bookkeeping
    logic         rsp_valid_q;
    logic         we_q;
    access_size_e size_q;
    logic [1:0]   off_q;
    logic         uns_q;

    logic [BUS_DATA_WIDTH-1:0] lane;   // addressed bytes moved to bit 0
    logic [BUS_DATA_WIDTH-1:0] rdata;

    assign off = cmd_addr_i[1:0];

    // byte mask from size and offset
    always_comb begin
        case (cmd_size_i)
            SIZE_BYTE: mask = 4'b0001 << off;
            SIZE_HALF: mask = 4'b0011 << {off[1], 1'b0};  // halfword stays aligned
            SIZE_WORD: mask = 4'b1111;
            default:   mask = 4'b0000;
        endcase
    end

    // request, same cycle as the command
    assign ex_req_o   = cmd_valid_i;
    assign ex_addr_o  = {cmd_addr_i[BUS_ADDR_WIDTH-1:2], 2'b00};
    assign ex_we_o    = cmd_valid_i && cmd_we_i;
    assign ex_wmask_o = ex_we_o ? mask : 4'b0000;  // no lanes on a load

    // replicate store data over all lanes, mask picks the right ones
    always_comb begin
        case (cmd_size_i)
            SIZE_BYTE: ex_wdata_o = {4{cmd_wdata_i[7:0]}};
            SIZE_HALF: ex_wdata_o = {2{cmd_wdata_i[15:0]}};
            default:   ex_wdata_o = cmd_wdata_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= cmd_valid_i;  // every command answers once
        end
    end

    // how to unpack the returning word
    always_ff @(posedge clk) begin
        we_q   <= cmd_we_i;
        size_q <= cmd_size_i;
        off_q  <= off;
        uns_q  <= cmd_unsigned_i;
    end

    // lane extraction and extension
    always_comb begin
        lane  = ex_rdata_i >> {off_q, 3'b000};
        case (size_q)
            SIZE_BYTE: rdata = {{(BUS_DATA_WIDTH-8){!uns_q && lane[7]}}, lane[7:0]};
            SIZE_HALF: rdata = {{(BUS_DATA_WIDTH-16){!uns_q && lane[15]}}, lane[15:0]};
            default:   rdata = ex_rdata_i;
        endcase
        if (!rsp_valid_q || we_q || ex_err_i) begin
            rdata = '0;  // stores and misses carry no data
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rdata;
    assign rsp_err_o   = rsp_valid_q && ex_err_i;

endmodule

// File: hdl/tcm_mems.sv
`timescale 1ns/1ps

// itcm + dtcm block
// load/store side wins the itcm port, fetch gets a nop and is held
module tcm_mems #(
    parameter int ITCM_ADDR_WIDTH = 8,  // itcm word address width
    parameter int DTCM_ADDR_WIDTH = 8   // dtcm word address width
) (
    input  logic clk,
    input  logic rst_n_i,

    // fetch side
    input  logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] pc_i,        // fetch address
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] inst_o,      // fetched word, one cycle later
    output logic                               hold_flag_o, // fetch stalled this cycle

    // load/store side
    input  logic                               ex_req_i,
    input  logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] ex_addr_i,   // word aligned byte address
    input  logic                               ex_we_i,
    input  logic [3:0]                         ex_wmask_i,
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] ex_wdata_i,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] ex_rdata_o,  // one cycle after request
    output logic                               ex_err_o     // previous request hit nothing
);

    import tcm_pkg::*;

    // region offsets
    logic [BUS_ADDR_WIDTH-1:0] itcm_off;   // ex address relative to itcm base
    logic [BUS_ADDR_WIDTH-1:0] dtcm_off;   // ex address relative to dtcm base
    logic [BUS_ADDR_WIDTH-1:0] pc_off;     // fetch address relative to itcm base

    // decode
    logic itcm_sel;  // ex request lands in itcm
    logic dtcm_sel;  // ex request lands in dtcm
    logic miss;      // ex request outside both windows

    // select of the previous cycle
    logic itcm_sel_q;
    logic dtcm_sel_q;
    logic err_q;

    // itcm port
    logic [ITCM_ADDR_WIDTH-1:0] itcm_addr;
    logic                       itcm_we;
    logic [3:0]                 itcm_wmask;
    logic [BUS_DATA_WIDTH-1:0]  itcm_rdata;

    // dtcm port
    logic [DTCM_ADDR_WIDTH-1:0] dtcm_addr;
    logic                       dtcm_we;
    logic [3:0]                 dtcm_wmask;
    logic [BUS_DATA_WIDTH-1:0]  dtcm_rdata;

    assign itcm_off = ex_addr_i - ITCM_BASE_ADDR;
    assign dtcm_off = ex_addr_i - DTCM_BASE_ADDR;
    assign pc_off   = pc_i - ITCM_BASE_ADDR;

    // in range when nothing is set above the window size
    assign itcm_sel = ex_req_i && (itcm_off[BUS_ADDR_WIDTH-1:ITCM_ADDR_WIDTH+2] == '0);
    assign dtcm_sel = ex_req_i && (dtcm_off[BUS_ADDR_WIDTH-1:DTCM_ADDR_WIDTH+2] == '0);
    assign miss     = ex_req_i && !itcm_sel && !dtcm_sel;

    // itcm arbitration, ex over fetch
    assign itcm_addr  = itcm_sel ? itcm_off[ITCM_ADDR_WIDTH+1:2] : pc_off[ITCM_ADDR_WIDTH+1:2];
    assign itcm_we    = itcm_sel && ex_we_i;  // fetch never writes
    assign itcm_wmask = itcm_sel ? ex_wmask_i : 4'b0000;

    assign hold_flag_o = itcm_sel;  // fetch loses the port this cycle

    // dtcm only ever serves ex
    assign dtcm_addr  = dtcm_off[DTCM_ADDR_WIDTH+1:2];
    assign dtcm_we    = dtcm_sel && ex_we_i;
    assign dtcm_wmask = dtcm_sel ? ex_wmask_i : 4'b0000;

    // remember who owned each ram, read data shows up next cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            itcm_sel_q <= 1'b0;
            dtcm_sel_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            itcm_sel_q <= itcm_sel;
            dtcm_sel_q <= dtcm_sel;
            err_q      <= miss;
        end
    end

    // return steering
    assign ex_rdata_o = itcm_sel_q ? itcm_rdata :
                        dtcm_sel_q ? dtcm_rdata : '0;  // zero on a miss or idle
    assign inst_o     = itcm_sel_q ? NOP_INST : itcm_rdata;
    assign ex_err_o   = err_q;

    tcm_ram #(
        .ADDR_WIDTH(ITCM_ADDR_WIDTH)
    ) itcm_inst (
        .clk    (clk),
        .we_i   (itcm_we),
        .wmask_i(itcm_wmask),
        .addr_i (itcm_addr),
        .wdata_i(ex_wdata_i),
        .rdata_o(itcm_rdata)
    );

    tcm_ram #(
        .ADDR_WIDTH(DTCM_ADDR_WIDTH)
    ) dtcm_inst (
        .clk    (clk),
        .we_i   (dtcm_we),
        .wmask_i(dtcm_wmask),
        .addr_i (dtcm_addr),
        .wdata_i(ex_wdata_i),
        .rdata_o(dtcm_rdata)
    );

endmodule

// File: hdl/tcm_pkg.sv
// shared definitions for the tcm subsystem
package tcm_pkg;

    // bus widths
    localparam int BUS_ADDR_WIDTH = 32;  // byte address
    localparam int BUS_DATA_WIDTH = 32;  // data and instruction word

    // address map
    // itcm at the bottom of the space, dtcm higher up
    localparam logic [BUS_ADDR_WIDTH-1:0] ITCM_BASE_ADDR = 32'h0000_0000;
    localparam logic [BUS_ADDR_WIDTH-1:0] DTCM_BASE_ADDR = 32'h1000_0000;

    // addi x0, x0, 0
    // handed to fetch while the itcm port is taken by a load/store
    localparam logic [BUS_DATA_WIDTH-1:0] NOP_INST = 32'h0000_0013;

    // load/store access size
    // encoding follows funct3[1:0] of the rv32 load/store opcodes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,  // lb / lbu / sb
        SIZE_HALF = 2'b01,  // lh / lhu / sh
        SIZE_WORD = 2'b10   // lw / sw
    } access_size_e;

endpackage

// File: hdl/tcm_ram.sv
`timescale 1ns/1ps

// single port ram
// one word per address, byte lane write enables, registered read
module tcm_ram #(
    parameter int ADDR_WIDTH = 8  // word address width
) (
    input  logic                              clk,
    input  logic                              we_i,     // write strobe
    input  logic [3:0]                        wmask_i,  // one bit per byte lane
    input  logic [ADDR_WIDTH-1:0]             addr_i,   // word address
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] wdata_i,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] rdata_o
);

    import tcm_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int LANES = 4;

    // storage array, contents undefined until written
    logic [BUS_DATA_WIDTH-1:0] mem [DEPTH];

    // byte masked write path
    always_ff @(posedge clk) begin
        for (int b = 0; b < LANES; b++) begin
            if (we_i && wmask_i[b]) begin
                mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];  // only enabled lanes
            end
        end
    end

    // read path
    // old contents come out on a same cycle write (read first)
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];  // data valid next cycle
    end

endmodule

// File: hdl/tcm_subsys_top.sv
`timescale 1ns/1ps

// tcm subsystem top
// fetch unit and lsu sharing the itcm through the memory block
module tcm_subsys_top #(
    parameter int ITCM_ADDR_WIDTH = 8,  // 1 KiB itcm
    parameter int DTCM_ADDR_WIDTH = 8   // 1 KiB dtcm
) (
    input  logic clk,
    input  logic rst_n_i,

    // load/store commands
    input  logic                               cmd_valid_i,
    input  logic                               cmd_we_i,
    input  logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] cmd_addr_i,
    input  tcm_pkg::access_size_e              cmd_size_i,
    input  logic                               cmd_unsigned_i,
    input  logic [tcm_pkg::BUS_DATA_WIDTH-1:0] cmd_wdata_i,

    // fetch results
    output logic                               inst_valid_o,
    output logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] inst_pc_o,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] inst_data_o,

    // load/store responses
    output logic                               rsp_valid_o,
    output logic [tcm_pkg::BUS_DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                               rsp_err_o
);

    import tcm_pkg::*;

    // fetch <-> memory block
    logic [BUS_ADDR_WIDTH-1:0] pc;
    logic [BUS_DATA_WIDTH-1:0] inst;
    logic                      hold_flag;

    // lsu <-> memory block
    logic                      ex_req;
    logic [BUS_ADDR_WIDTH-1:0] ex_addr;
    logic                      ex_we;
    logic [3:0]                ex_wmask;
    logic [BUS_DATA_WIDTH-1:0] ex_wdata;
    logic [BUS_DATA_WIDTH-1:0] ex_rdata;
    logic                      ex_err;

    fetch_unit #(
        .ITCM_ADDR_WIDTH(ITCM_ADDR_WIDTH)
    ) fetch_unit_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hold_i      (hold_flag),
        .inst_i      (inst),
        .pc_o        (pc),
        .inst_valid_o(inst_valid_o),
        .inst_pc_o   (inst_pc_o),
        .inst_data_o (inst_data_o)
    );

    tcm_mems #(
        .ITCM_ADDR_WIDTH(ITCM_ADDR_WIDTH),
        .DTCM_ADDR_WIDTH(DTCM_ADDR_WIDTH)
    ) tcm_mems_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pc_i       (pc),
        .inst_o     (inst),
        .hold_flag_o(hold_flag),
        .ex_req_i   (ex_req),
        .ex_addr_i  (ex_addr),
        .ex_we_i    (ex_we),
        .ex_wmask_i (ex_wmask),
        .ex_wdata_i (ex_wdata),
        .ex_rdata_o (ex_rdata),
        .ex_err_o   (ex_err)
    );

    lsu lsu_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_we_i      (cmd_we_i),
        .cmd_addr_i    (cmd_addr_i),
        .cmd_size_i    (cmd_size_i),
        .cmd_unsigned_i(cmd_unsigned_i),
        .cmd_wdata_i   (cmd_wdata_i),
        .ex_req_o      (ex_req),
        .ex_addr_o     (ex_addr),
        .ex_we_o       (ex_we),
        .ex_wmask_o    (ex_wmask),
        .ex_wdata_o    (ex_wdata),
        .ex_rdata_i    (ex_rdata),
        .ex_err_i      (ex_err),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .rsp_err_o     (rsp_err_o)
    );

endmodule

// File: sim.f
hdl/tcm_pkg.sv
hdl/tcm_ram.sv
hdl/tcm_mems.sv
hdl/fetch_unit.sv
hdl/lsu.sv
hdl/tcm_subsys_top.sv
verification/tcm_subsys_sva.sv
verification/tb_tcm_subsys.sv

// File: verification/tb_tcm_subsys.sv
`timescale 1ns/1ps

module tb_tcm_subsys;

    import tcm_pkg::*;

    localparam int ITCM_BYTES = 4 * (2 ** 8);  // top level default widths
    localparam int DTCM_BYTES = 4 * (2 ** 8);
    localparam int ITCM_WORDS = ITCM_BYTES / 4;
    localparam int DTCM_WORDS = DTCM_BYTES / 4;

    // test lengths in cycles
    localparam int RESET_CYCLES   = 8;
    localparam int T1_CYCLES      = 4;
    localparam int FETCH_RUN      = 300;                     // more than one lap of the itcm
    localparam int T2_CYCLES      = 2 * ITCM_WORDS + FETCH_RUN;  // at most one gap per store
    localparam int T3_RANDOM      = 400;
    localparam int T3_CYCLES      = DTCM_WORDS + T3_RANDOM;
    localparam int T4_CYCLES      = 300;
    localparam int T5_CYCLES      = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                    + T4_CYCLES + T5_CYCLES + 100;

    logic         clk;
    logic         rst_n;
    logic         cmd_valid;
    logic         cmd_we;
    logic [31:0]  cmd_addr;
    access_size_e cmd_size;
    logic         cmd_unsigned;
    logic [31:0]  cmd_wdata;
    logic         inst_valid;
    logic [31:0]  inst_pc;
    logic [31:0]  inst_data;
    logic         rsp_valid;
    logic [31:0]  rsp_rdata;
    logic         rsp_err;

    logic [7:0]  itcm_m [ITCM_BYTES];  // byte models, x until written
    logic [7:0]  dtcm_m [DTCM_BYTES];
    logic [31:0] pc_m;                 // next fetch address
    logic [31:0] rng;

    // expected values for the cycle in flight
    logic        exp_inst_valid;
    logic [31:0] exp_inst_pc;
    logic [31:0] exp_inst_data;
    logic        exp_rsp_valid;
    logic        exp_rsp_err;
    logic [31:0] exp_rsp_rdata;

    int checks = 0;
    int errors = 0;
    int chk_base = 0;
    int err_base = 0;
    int cycle_cnt = 0;

    tcm_subsys_top tcm_subsys_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .cmd_valid_i   (cmd_valid),
        .cmd_we_i      (cmd_we),
        .cmd_addr_i    (cmd_addr),
        .cmd_size_i    (cmd_size),
        .cmd_unsigned_i(cmd_unsigned),
        .cmd_wdata_i   (cmd_wdata),
        .inst_valid_o  (inst_valid),
        .inst_pc_o     (inst_pc),
        .inst_data_o   (inst_data),
        .rsp_valid_o   (rsp_valid),
        .rsp_rdata_o   (rsp_rdata),
        .rsp_err_o     (rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic in_itcm(input logic [31:0] a);
        return (a - ITCM_BASE_ADDR) < 32'(ITCM_BYTES);
    endfunction

    function automatic logic in_dtcm(input logic [31:0] a);
        return (a - DTCM_BASE_ADDR) < 32'(DTCM_BYTES);
    endfunction

    function automatic int size_bytes(input logic [1:0] sz);
        return (sz == 2'b00) ? 1 : (sz == 2'b01) ? 2 : 4;
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] a);
        if (in_itcm(a)) return itcm_m[a - ITCM_BASE_ADDR];
        if (in_dtcm(a)) return dtcm_m[a - DTCM_BASE_ADDR];
        return 8'h00;
    endfunction

    // little endian gather, then sign or zero extension
    function automatic logic [31:0] load_value(input logic [31:0] a, input logic [1:0] sz,
                                               input logic uns);
        logic [31:0] w;
        int n;
        n = size_bytes(sz);
        w = '0;
        for (int i = 0; i < n; i++) w[8*i +: 8] = read_byte(a + i);
        if (!uns && n < 4 && w[8*n-1]) begin
            for (int i = n; i < 4; i++) w[8*i +: 8] = 8'hff;
        end
        return w;
    endfunction

    task automatic write_byte(input logic [31:0] a, input logic [7:0] d);
        if (in_itcm(a)) itcm_m[a - ITCM_BASE_ADDR] = d;
        else if (in_dtcm(a)) dtcm_m[a - DTCM_BASE_ADDR] = d;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one cycle: predict, drive on the falling edge, check a cycle later, then commit stores
    task automatic step(input logic v, input logic we, input logic [31:0] a,
                        input logic [1:0] sz, input logic uns, input logic [31:0] wd);
        logic hit_itcm;
        logic miss;
        hit_itcm = v && in_itcm(a);  // itcm access holds fetch
        miss     = v && !in_itcm(a) && !in_dtcm(a);
        exp_inst_valid = !hit_itcm;
        exp_inst_pc    = pc_m;
        exp_inst_data  = load_value(pc_m, 2'b10, 1'b1);
        if (!hit_itcm) begin
            pc_m = ITCM_BASE_ADDR + ((pc_m - ITCM_BASE_ADDR + 4) % 32'(ITCM_BYTES));  // wrap
        end
        exp_rsp_valid = v;
        exp_rsp_err   = miss;
        exp_rsp_rdata = (v && !we && !miss) ? load_value(a, sz, uns) : '0;
        cmd_valid    = v;
        cmd_we       = we;
        cmd_addr     = a;
        cmd_size     = access_size_e'(sz);
        cmd_unsigned = uns;
        cmd_wdata    = wd;
        @(negedge clk);
        check("inst_valid_o", inst_valid, exp_inst_valid);
        if (exp_inst_valid) begin
            check("inst_pc_o", inst_pc, exp_inst_pc);
            if (!$isunknown(exp_inst_data)) check("inst_data_o", inst_data, exp_inst_data);
        end
        check("rsp_valid_o", rsp_valid, exp_rsp_valid);
        if (exp_rsp_valid) begin
            check("rsp_err_o", rsp_err, exp_rsp_err);
            check("rsp_rdata_o", rsp_rdata, exp_rsp_rdata);
        end
        if (v && we && !miss) begin
            for (int i = 0; i < size_bytes(sz); i++) write_byte(a + i, wd[8*i +: 8]);
        end
    endtask

    task automatic idle();
        step(1'b0, 1'b0, '0, 2'b10, 1'b0, '0);
    endtask

    // naturally aligned random access, extra bits push it out of range
    task automatic rand_access(input logic [31:0] base, input int words, input logic stores,
                               input logic [31:0] out_bits);
        logic [31:0] r;
        logic [1:0]  sz;
        logic [31:0] a;
        r  = next_rand();
        sz = (r[1:0] == 2'b11) ? 2'b10 : r[1:0];
        a  = base + 4 * (next_rand() % words);
        if (sz == 2'b00) a = a + r[3:2];
        else if (sz == 2'b01) a = a + {r[3], 1'b0};
        step(1'b1, stores && r[4], a | out_bits, sz, r[5], next_rand());
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
        chk_base = checks;
        err_base = errors;
    endtask

    initial begin
        logic [31:0] r;
        rng = 32'h45145c27;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_we = 1'b0;
        cmd_addr = '0;
        cmd_size = SIZE_WORD;
        cmd_unsigned = 1'b0;
        cmd_wdata = '0;
        pc_m = ITCM_BASE_ADDR;
        repeat (RESET_CYCLES) @(negedge clk);
        check("inst_valid_o", inst_valid, 1'b0);
        check("rsp_valid_o", rsp_valid, 1'b0);
        check("rsp_err_o", rsp_err, 1'b0);
        rst_n = 1'b1;
        repeat (T1_CYCLES) idle();  // first strobe must carry the itcm base
        end_test("test 1 reset");

        for (int i = 0; i < ITCM_WORDS; i++) begin
            r = next_rand();
            if (r[0]) idle();  // lets fetch run between stores
            step(1'b1, 1'b1, ITCM_BASE_ADDR + 4 * i, 2'b10, 1'b0, next_rand());
        end
        repeat (FETCH_RUN) idle();
        end_test("test 2 itcm preload and fetch");

        for (int i = 0; i < DTCM_WORDS; i++) begin
            step(1'b1, 1'b1, DTCM_BASE_ADDR + 4 * i, 2'b10, 1'b0, next_rand());
        end
        repeat (T3_RANDOM) rand_access(DTCM_BASE_ADDR, DTCM_WORDS, 1'b1, '0);
        end_test("test 3 dtcm random access");

        for (int i = 0; i < T4_CYCLES; i++) begin
            r = next_rand();
            if (r[1:0] == 2'b00) idle();
            else rand_access(ITCM_BASE_ADDR, ITCM_WORDS, 1'b1, '0);
        end
        end_test("test 4 itcm access with fetch");

        // misses mixed with loads that show both memories unchanged
        for (int i = 0; i < T5_CYCLES; i++) begin
            r = next_rand();
            if (r[0]) begin
                rand_access(r[1] ? ITCM_BASE_ADDR : DTCM_BASE_ADDR, ITCM_WORDS, 1'b1,
                            32'h0000_1000);
            end else begin
                rand_access(r[1] ? ITCM_BASE_ADDR : DTCM_BASE_ADDR, ITCM_WORDS, 1'b0, '0);
            end
        end
        end_test("test 5 out of range access");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/tcm_subsys_sva.sv
`timescale 1ns/1ps

// checks across the memory block, the fetch unit and the lsu
// hold, fetch strobe and response timing seen from the top level wiring
module tcm_subsys_sva #(
    parameter int ITCM_ADDR_WIDTH = 8
) (
    input logic                               clk,
    input logic                               rst_n_i,
    input logic                               cmd_valid_i,  // load/store command
    input logic [tcm_pkg::BUS_ADDR_WIDTH-1:0] cmd_addr_i,   // byte address of the command
    input logic                               hold_i,       // fetch held
    input logic                               inst_valid_i, // fetch result strobe
    input logic                               rsp_valid_i
);

    import tcm_pkg::*;

    localparam int ITCM_BYTES = 4 * (2 ** ITCM_ADDR_WIDTH);  // itcm window size

    logic cmd_in_itcm;

    assign cmd_in_itcm = (cmd_addr_i - ITCM_BASE_ADDR) < BUS_ADDR_WIDTH'(ITCM_BYTES);

    hold_only_on_itcm: assert property (@(posedge clk) disable iff (!rst_n_i)
        hold_i |-> cmd_valid_i && cmd_in_itcm)
        else $error("hold raised without a load/store inside the itcm");

    // the issue lost to a load/store never shows up as a fetch result
    no_fetch_after_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        hold_i |=> !inst_valid_i)
        else $error("fetch strobe right after a held cycle");

    rsp_after_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd_valid_i |=> rsp_valid_i)
        else $error("command without a response one cycle later");

    no_rsp_without_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
        !cmd_valid_i |=> !rsp_valid_i)
        else $error("response without a command one cycle earlier");

endmodule

bind tcm_subsys_top tcm_subsys_sva #(
    .ITCM_ADDR_WIDTH(ITCM_ADDR_WIDTH)
) sva_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_addr_i  (cmd_addr_i),
    .hold_i      (hold_flag),
    .inst_valid_i(inst_valid_o),
    .rsp_valid_i (rsp_valid_o)
);
